/* source/fir_pkg.sv */
////////////////////
// FIR block shared definitions
// Widths, tap count, settings and readback addresses, sample types
////////////////////
package fir_pkg;

  // Datapath widths
  localparam int SAMPLE_W  = 16;
  localparam int COEFF_W   = 16;
  localparam int PROD_W    = SAMPLE_W + COEFF_W;
  localparam int ACC_W     = PROD_W + 3;
  localparam int FRAC_BITS = 15;
  localparam int NUM_TAPS  = 8;

  // Output clip limits
  localparam int SAMPLE_MAX = 32767;
  localparam int SAMPLE_MIN = -32768;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [COEFF_W-1:0]  coeff_t;
  typedef logic signed [PROD_W-1:0]   prod_t;
  typedef logic signed [ACC_W-1:0]    acc_t;

  // Settings bus addresses
  localparam logic [7:0] SR_COEFF_ADDR      = 8'd129;
  localparam logic [7:0] SR_COEFF_LAST_ADDR = 8'd130;

  // Readback addresses
  localparam logic [7:0]  RB_NUM_TAPS     = 8'd0;
  localparam logic [7:0]  RB_RELOAD_COUNT = 8'd1;
  localparam logic [63:0] RB_DEFAULT      = 64'h0BADC0DE0BADC0DE;

  // Tap 0 after reset is one half, the rest are zero
  localparam coeff_t COEFF_RESET_C0 = 16'sh4000;

endpackage

/* source/fir_settings_regs.sv */
////////////////////
// FIR settings registers
// Coefficient write decode, reload counter and readback mux
////////////////////
`timescale 1ns/1ps

module fir_settings_regs
  import fir_pkg::*;
(
  input  logic        i_ce_clk,
  input  logic        i_arst_n,
  // Settings bus
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  // Reload finished in the coefficient bank
  input  logic        i_commit_done,
  // Readback
  input  logic [7:0]  i_rb_addr,
  // Coefficient bank controls
  output logic        o_coeff_load,
  output logic        o_coeff_commit,
  output coeff_t      o_coeff_data,
  output logic [63:0] o_rb_data
);

  logic [31:0] reload_count;
  logic        hit_coeff;
  logic        hit_last;

  ////////////////////
  // Write decode
  ////////////////////
  assign hit_coeff = i_set_stb && (i_set_addr == SR_COEFF_ADDR);
  assign hit_last  = i_set_stb && (i_set_addr == SR_COEFF_LAST_ADDR);

  // The last write shifts in too
  assign o_coeff_load   = hit_coeff || hit_last;
  assign o_coeff_commit = hit_last;
  assign o_coeff_data   = i_set_data[COEFF_W-1:0];

  // Completed reloads
  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      reload_count <= '0;
    end else if (i_commit_done) begin
      reload_count <= reload_count + 32'd1;
    end
  end

  ////////////////////
  // Readback
  ////////////////////
  always_comb begin
    case (i_rb_addr)
      RB_NUM_TAPS:     o_rb_data = 64'(NUM_TAPS);
      RB_RELOAD_COUNT: o_rb_data = {32'd0, reload_count};
      default:         o_rb_data = RB_DEFAULT;
    endcase
  end

endmodule

/* source/fir_coeff_bank.sv */
////////////////////
// FIR coefficient bank
// Shadow shift chain with atomic copy into the active set
////////////////////
`timescale 1ns/1ps

module fir_coeff_bank
  import fir_pkg::*;
(
  input  logic                    i_ce_clk,
  input  logic                    i_arst_n,
  input  logic                    i_coeff_load,
  input  logic                    i_coeff_commit,
  input  coeff_t                  i_coeff_data,
  output coeff_t [NUM_TAPS-1:0]   o_coeffs,
  output logic                    o_commit_done
);

  coeff_t [NUM_TAPS-1:0] shadow;
  coeff_t [NUM_TAPS-1:0] active;
  coeff_t [NUM_TAPS-1:0] shadow_next;
  coeff_t [NUM_TAPS-1:0] reset_set;

  assign reset_set = {{((NUM_TAPS-1)*COEFF_W){1'b0}}, COEFF_RESET_C0};

  // New word enters tap 0, older words move up
  assign shadow_next = {shadow[NUM_TAPS-2:0], i_coeff_data};

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      shadow <= reset_set;
      active <= reset_set;
    end else begin
      if (i_coeff_load) begin
        shadow <= shadow_next;
      end
      // Commit sees the chain including this last word
      if (i_coeff_commit) begin
        active <= shadow_next;
      end
    end
  end

  assign o_coeffs      = active;
  assign o_commit_done = i_coeff_commit;

endmodule

/* source/fir_core.sv */
////////////////////
// FIR complex multiply/accumulate core
// Products then adder tree, two stalling stages
////////////////////
`timescale 1ns/1ps

module fir_core
  import fir_pkg::*;
(
  input  logic                  i_ce_clk,
  input  logic                  i_arst_n,
  // Sample input
  input  logic [31:0]           i_tdata,
  input  logic                  i_tlast,
  input  logic                  i_tvalid,
  output logic                  o_tready,
  // Active coefficients
  input  coeff_t [NUM_TAPS-1:0] i_coeffs,
  // Accumulator output
  output acc_t                  o_acc_i,
  output acc_t                  o_acc_q,
  output logic                  o_acc_last,
  output logic                  o_acc_valid,
  input  logic                  i_acc_ready
);

  sample_t [NUM_TAPS-2:0] hist_i;
  sample_t [NUM_TAPS-2:0] hist_q;
  sample_t [NUM_TAPS-1:0] tap_i;
  sample_t [NUM_TAPS-1:0] tap_q;
  prod_t   [NUM_TAPS-1:0] prod_i;
  prod_t   [NUM_TAPS-1:0] prod_q;
  prod_t   [NUM_TAPS-1:0] s1_prod_i;
  prod_t   [NUM_TAPS-1:0] s1_prod_q;
  logic                   s1_valid;
  logic                   s1_last;
  acc_t                   sum_i;
  acc_t                   sum_q;
  acc_t                   s2_acc_i;
  acc_t                   s2_acc_q;
  logic                   s2_valid;
  logic                   s2_last;
  logic                   advance;
  logic                   accept;

  // Whole pipeline moves with the output slot
  assign advance  = i_acc_ready;
  assign o_tready = advance;
  assign accept   = i_tvalid && advance;

  // Tap 0 is the incoming sample, tap k is k samples back
  assign tap_i = {hist_i, sample_t'(i_tdata[31:16])};
  assign tap_q = {hist_q, sample_t'(i_tdata[15:0])};

  always_comb begin
    for (int k = 0; k < NUM_TAPS; k++) begin
      prod_i[k] = tap_i[k] * i_coeffs[k];
      prod_q[k] = tap_q[k] * i_coeffs[k];
    end
  end

  ////////////////////
  // History and control
  ////////////////////
  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      hist_i   <= '0;
      hist_q   <= '0;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (advance) begin
      if (i_tvalid) begin
        hist_i <= tap_i[NUM_TAPS-2:0];
        hist_q <= tap_q[NUM_TAPS-2:0];
      end
      s1_valid <= i_tvalid;
      s2_valid <= s1_valid;
    end
  end

  // Adder tree over the registered products
  always_comb begin
    sum_i = '0;
    sum_q = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      sum_i = sum_i + s1_prod_i[k];
      sum_q = sum_q + s1_prod_q[k];
    end
  end

  ////////////////////
  // Stage payload
  ////////////////////
  always_ff @(posedge i_ce_clk) begin
    if (advance) begin
      if (accept) begin
        s1_prod_i <= prod_i;
        s1_prod_q <= prod_q;
      end
      s1_last  <= i_tlast;
      s2_acc_i <= sum_i;
      s2_acc_q <= sum_q;
      s2_last  <= s1_last;
    end
  end

  assign o_acc_i     = s2_acc_i;
  assign o_acc_q     = s2_acc_q;
  assign o_acc_last  = s2_last;
  assign o_acc_valid = s2_valid;

endmodule

/* source/fir_round_clip.sv */
////////////////////
// FIR complex round and clip
// Round half up, drop fraction bits, saturate to 16 bits
////////////////////
`timescale 1ns/1ps

module fir_round_clip
  import fir_pkg::*;
(
  input  logic        i_ce_clk,
  input  logic        i_arst_n,
  // Accumulator input
  input  acc_t        i_acc_i,
  input  acc_t        i_acc_q,
  input  logic        i_acc_last,
  input  logic        i_acc_valid,
  output logic        o_acc_ready,
  // Sample output, I in the upper half
  output logic [31:0] o_tdata,
  output logic        o_tlast,
  output logic        o_tvalid,
  input  logic        i_tready
);

  sample_t out_i;
  sample_t out_q;

  function automatic sample_t round_clip(input acc_t a);
    acc_t r;
    r = a + (acc_t'(1) <<< (FRAC_BITS - 1));
    r = r >>> FRAC_BITS;
    if (r > SAMPLE_MAX) begin
      return sample_t'(SAMPLE_MAX);
    end else if (r < SAMPLE_MIN) begin
      return sample_t'(SAMPLE_MIN);
    end
    return r[SAMPLE_W-1:0];
  endfunction

  // Slot free or draining this cycle
  assign o_acc_ready = !o_tvalid || i_tready;

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_tvalid <= 1'b0;
    end else if (o_acc_ready) begin
      o_tvalid <= i_acc_valid;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (o_acc_ready && i_acc_valid) begin
      out_i   <= round_clip(i_acc_i);
      out_q   <= round_clip(i_acc_q);
      o_tlast <= i_acc_last;
    end
  end

  assign o_tdata = {out_i, out_q};

endmodule

/* source/fir_block_top.sv */
////////////////////
// Streaming complex FIR block
////////////////////
`timescale 1ns/1ps

module fir_block_top
  import fir_pkg::*;
(
  input  logic        i_ce_clk,
  input  logic        i_arst_n,
  // Sample input
  input  logic [31:0] i_tdata,
  input  logic        i_tlast,
  input  logic        i_tvalid,
  output logic        o_tready,
  // Sample output
  output logic [31:0] o_tdata,
  output logic        o_tlast,
  output logic        o_tvalid,
  input  logic        i_tready,
  // Settings bus
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  // Readback
  input  logic [7:0]  i_rb_addr,
  output logic [63:0] o_rb_data
);

  logic                  coeff_load;
  logic                  coeff_commit;
  logic                  commit_done;
  coeff_t                coeff_data;
  coeff_t [NUM_TAPS-1:0] coeffs;
  acc_t                  acc_i;
  acc_t                  acc_q;
  logic                  acc_last;
  logic                  acc_valid;
  logic                  acc_ready;

  ////////////////////
  // Control path
  ////////////////////
  fir_settings_regs fir_settings_regs_i (
    .i_ce_clk       (i_ce_clk),
    .i_arst_n       (i_arst_n),
    .i_set_stb      (i_set_stb),
    .i_set_addr     (i_set_addr),
    .i_set_data     (i_set_data),
    .i_commit_done  (commit_done),
    .i_rb_addr      (i_rb_addr),
    .o_coeff_load   (coeff_load),
    .o_coeff_commit (coeff_commit),
    .o_coeff_data   (coeff_data),
    .o_rb_data      (o_rb_data)
  );

  fir_coeff_bank fir_coeff_bank_i (
    .i_ce_clk       (i_ce_clk),
    .i_arst_n       (i_arst_n),
    .i_coeff_load   (coeff_load),
    .i_coeff_commit (coeff_commit),
    .i_coeff_data   (coeff_data),
    .o_coeffs       (coeffs),
    .o_commit_done  (commit_done)
  );

  ////////////////////
  // Data path
  ////////////////////
  fir_core fir_core_i (
    .i_ce_clk    (i_ce_clk),
    .i_arst_n    (i_arst_n),
    .i_tdata     (i_tdata),
    .i_tlast     (i_tlast),
    .i_tvalid    (i_tvalid),
    .o_tready    (o_tready),
    .i_coeffs    (coeffs),
    .o_acc_i     (acc_i),
    .o_acc_q     (acc_q),
    .o_acc_last  (acc_last),
    .o_acc_valid (acc_valid),
    .i_acc_ready (acc_ready)
  );

  fir_round_clip fir_round_clip_i (
    .i_ce_clk    (i_ce_clk),
    .i_arst_n    (i_arst_n),
    .i_acc_i     (acc_i),
    .i_acc_q     (acc_q),
    .i_acc_last  (acc_last),
    .i_acc_valid (acc_valid),
    .o_acc_ready (acc_ready),
    .o_tdata     (o_tdata),
    .o_tlast     (o_tlast),
    .o_tvalid    (o_tvalid),
    .i_tready    (i_tready)
  );

endmodule

/* testbench/fir_checker.sv */
////////////////////
// FIR block checker
// Reference filter model, compares every output transfer
////////////////////
`timescale 1ns/1ps

module fir_checker
  import fir_pkg::*;
(
  input  logic        i_ce_clk,
  input  logic        i_arst_n,
  // DUT sample input
  input  logic [31:0] i_in_data,
  input  logic        i_in_last,
  input  logic        i_in_valid,
  input  logic        i_in_ready,
  // DUT sample output
  input  logic [31:0] i_out_data,
  input  logic        i_out_last,
  input  logic        i_out_valid,
  input  logic        i_out_ready,
  // Settings bus
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  // Progress and error counts
  output int          o_in_count,
  output int          o_out_count,
  output int          o_pending,
  output int          o_errors
);

  int          shadow[NUM_TAPS];
  int          active[NUM_TAPS];
  int          hist_i[NUM_TAPS];
  int          hist_q[NUM_TAPS];
  logic [32:0] expected[$];

  // Add half an LSB, drop the fraction, clip to 16 bits
  function automatic logic [15:0] scale_sample(input longint acc);
    longint r;
    r = (acc + (64'sd1 <<< (FRAC_BITS - 1))) >>> FRAC_BITS;
    if (r > 64'sd32767) begin
      r = 64'sd32767;
    end else if (r < -64'sd32768) begin
      r = -64'sd32768;
    end
    return r[15:0];
  endfunction

  function automatic logic [15:0] filter_rail(input int h[NUM_TAPS]);
    longint acc;
    acc = 0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      acc += longint'(active[k]) * longint'(h[k]);
    end
    return scale_sample(acc);
  endfunction

  always @(posedge i_ce_clk or negedge i_arst_n) begin
    logic [32:0] exp_word;
    if (!i_arst_n) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        shadow[k] = 0;
        active[k] = 0;
        hist_i[k] = 0;
        hist_q[k] = 0;
      end
      // One half in Q1.15 on tap 0
      shadow[0] = 16384;
      active[0] = 16384;
      expected.delete();
      o_in_count  = 0;
      o_out_count = 0;
      o_pending   = 0;
      o_errors    = 0;
    end else begin
      // Input side takes a sample whenever the output slot is free or draining
      if (i_in_ready !== (!i_out_valid || i_out_ready)) begin
        $display("Error at %0t: o_tready expected %b got %b",
                 $time, !i_out_valid || i_out_ready, i_in_ready);
        o_errors++;
      end
      // Outputs first, an input on this edge cannot leave yet
      if (i_out_valid && i_out_ready) begin
        if (expected.size() == 0) begin
          $display("Output transfer at %0t while no sample was expected", $time);
          o_errors++;
        end else begin
          exp_word = expected.pop_front();
          if (i_out_data !== exp_word[31:0]) begin
            $display("Error at %0t: o_tdata expected %08h got %08h",
                     $time, exp_word[31:0], i_out_data);
            o_errors++;
          end
          if (i_out_last !== exp_word[32]) begin
            $display("Error at %0t: o_tlast expected %b got %b",
                     $time, exp_word[32], i_out_last);
            o_errors++;
          end
        end
        o_out_count++;
      end
      // Input sees the set that was active before this edge
      if (i_in_valid && i_in_ready) begin
        for (int k = NUM_TAPS - 1; k > 0; k--) begin
          hist_i[k] = hist_i[k-1];
          hist_q[k] = hist_q[k-1];
        end
        hist_i[0] = int'($signed(i_in_data[31:16]));
        hist_q[0] = int'($signed(i_in_data[15:0]));
        expected.push_back({i_in_last, filter_rail(hist_i), filter_rail(hist_q)});
        o_in_count++;
      end
      // Coefficient writes shift the shadow chain, the last one commits
      if (i_set_stb && (i_set_addr == SR_COEFF_ADDR || i_set_addr == SR_COEFF_LAST_ADDR)) begin
        for (int k = NUM_TAPS - 1; k > 0; k--) begin
          shadow[k] = shadow[k-1];
        end
        shadow[0] = int'($signed(i_set_data[15:0]));
        if (i_set_addr == SR_COEFF_LAST_ADDR) begin
          active = shadow;
        end
      end
      o_pending = expected.size();
    end
  end

endmodule

/* testbench/tb_fir_block.sv */
////////////////////
// FIR block testbench
// Seeded random streams, coefficient reloads and saturation
////////////////////
`timescale 1ns/1ps

module tb_fir_block
  import fir_pkg::*;
();

  // Sample transfers over all tests
  localparam int PLANNED_XFERS = 10 + 300 + 4 * 40 + 24;
  localparam int WATCHDOG_CYCLES = PLANNED_XFERS * 4 + 2000;

  logic        i_ce_clk;
  logic        i_arst_n;
  logic [31:0] i_tdata;
  logic        i_tlast;
  logic        i_tvalid;
  logic        o_tready;
  logic [31:0] o_tdata;
  logic        o_tlast;
  logic        o_tvalid;
  logic        i_tready;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  logic [7:0]  i_rb_addr;
  logic [63:0] o_rb_data;
  int          in_count;
  int          out_count;
  int          pending;
  int          chk_errors;
  int          tb_errors;
  int          tests_failed;
  int          err_mark;
  bit          bp_en;

  always #4 i_ce_clk = ~i_ce_clk;

  // Random back-pressure on the output
  always @(negedge i_ce_clk) begin
    if (bp_en) begin
      i_tready = ($urandom % 4) != 0;
    end
  end

  fir_block_top fir_block_top_i (
    .i_ce_clk   (i_ce_clk),
    .i_arst_n   (i_arst_n),
    .i_tdata    (i_tdata),
    .i_tlast    (i_tlast),
    .i_tvalid   (i_tvalid),
    .o_tready   (o_tready),
    .o_tdata    (o_tdata),
    .o_tlast    (o_tlast),
    .o_tvalid   (o_tvalid),
    .i_tready   (i_tready),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_rb_addr  (i_rb_addr),
    .o_rb_data  (o_rb_data)
  );

  fir_checker fir_checker_i (
    .i_ce_clk    (i_ce_clk),
    .i_arst_n    (i_arst_n),
    .i_in_data   (i_tdata),
    .i_in_last   (i_tlast),
    .i_in_valid  (i_tvalid),
    .i_in_ready  (o_tready),
    .i_out_data  (o_tdata),
    .i_out_last  (o_tlast),
    .i_out_valid (o_tvalid),
    .i_out_ready (i_tready),
    .i_set_stb   (i_set_stb),
    .i_set_addr  (i_set_addr),
    .i_set_data  (i_set_data),
    .o_in_count  (in_count),
    .o_out_count (out_count),
    .o_pending   (pending),
    .o_errors    (chk_errors)
  );

  // Hold valid until the checker has seen the transfer
  task automatic send_sample(input logic [31:0] data, input logic last);
    int start;
    start    = in_count;
    i_tdata  = data;
    i_tlast  = last;
    i_tvalid = 1'b1;
    @(negedge i_ce_clk);
    while (in_count == start) begin
      @(negedge i_ce_clk);
    end
    i_tvalid = 1'b0;
  endtask

  task automatic send_stream(input int count, input int max_gap);
    for (int n = 0; n < count; n++) begin
      repeat ($urandom_range(max_gap)) @(negedge i_ce_clk);
      send_sample($urandom, ($urandom % 8) == 0);
    end
  endtask

  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(negedge i_ce_clk);
    i_set_stb  = 1'b0;
  endtask

  // First word written lands on the highest tap
  task automatic load_coeffs(input logic [15:0] c[NUM_TAPS]);
    for (int k = NUM_TAPS - 1; k >= 0; k--) begin
      write_setting((k == 0) ? SR_COEFF_LAST_ADDR : SR_COEFF_ADDR, {16'h0, c[k]});
    end
  endtask

  task automatic check_rb(input logic [7:0] addr, input logic [63:0] exp_value);
    i_rb_addr = addr;
    @(negedge i_ce_clk);
    if (o_rb_data !== exp_value) begin
      $display("Error at %0t: o_rb_data at address %0d expected %h got %h",
               $time, addr, exp_value, o_rb_data);
      tb_errors++;
    end
  endtask

  task automatic drain();
    int waited;
    waited   = 0;
    bp_en    = 1'b0;
    i_tready = 1'b1;
    while (pending != 0 && waited < 50) begin
      @(negedge i_ce_clk);
      waited++;
    end
    if (pending != 0) begin
      $display("%0d expected outputs never came out of the DUT", pending);
      tb_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    drain();
    errs = tb_errors + chk_errors - err_mark;
    if (errs == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errs);
      tests_failed++;
    end
    err_mark = tb_errors + chk_errors;
  endtask

  initial begin
    logic [15:0] c[NUM_TAPS];
    int          cycles;
    void'($urandom(32'h22f0b40b));
    i_ce_clk     = 1'b0;
    i_arst_n     = 1'b0;
    i_tdata      = '0;
    i_tlast      = 1'b0;
    i_tvalid     = 1'b0;
    i_tready     = 1'b1;
    i_set_stb    = 1'b0;
    i_set_addr   = '0;
    i_set_data   = '0;
    i_rb_addr    = '0;
    bp_en        = 1'b0;
    tb_errors    = 0;
    tests_failed = 0;
    err_mark     = 0;
    repeat (4) @(negedge i_ce_clk);
    i_arst_n = 1'b1;
    @(negedge i_ce_clk);

    ////////////////////
    // Test 1 reset state
    if (o_tvalid !== 1'b0) begin
      $display("Error at %0t: o_tvalid expected 0 got %b", $time, o_tvalid);
      tb_errors++;
    end
    check_rb(RB_NUM_TAPS, 64'(NUM_TAPS));
    check_rb(RB_RELOAD_COUNT, 64'd0);
    check_rb(8'd7, RB_DEFAULT);
    finish_test("Test 1 reset state");

    ////////////////////
    // Test 2 impulse through the default half-gain tap
    i_tdata  = 32'h04D3_FCF7;
    i_tlast  = 1'b0;
    i_tvalid = 1'b1;
    @(negedge i_ce_clk);
    i_tvalid = 1'b0;
    i_tdata  = '0;
    cycles   = 1;
    while (!o_tvalid && cycles < 10) begin
      @(negedge i_ce_clk);
      cycles++;
    end
    if (cycles != 3) begin
      $display("First output came %0d cycles after the accept, 3 expected", cycles);
      tb_errors++;
    end
    for (int n = 0; n < 9; n++) begin
      send_sample(32'h0, n == 8);
    end
    finish_test("Test 2 default response");

    ////////////////////
    // Test 3 random stream with back-pressure
    bp_en = 1'b1;
    send_stream(300, 3);
    finish_test("Test 3 random stream");

    ////////////////////
    // Test 4 reloads landing before, inside and after bursts
    for (int r = 0; r < 4; r++) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        c[k] = 16'($urandom_range(16383)) - 16'd8192;
      end
      bp_en    = (r % 2) == 1;
      i_tready = 1'b1;
      fork
        send_stream(40, r % 2);
        begin
          repeat ($urandom_range(60)) @(negedge i_ce_clk);
          load_coeffs(c);
        end
      join
      check_rb(RB_RELOAD_COUNT, 64'(r + 1));
    end
    finish_test("Test 4 coefficient reload");

    ////////////////////
    // Test 5 full-scale taps and inputs
    for (int k = 0; k < NUM_TAPS; k++) begin
      c[k] = 16'h7FFF;
    end
    load_coeffs(c);
    check_rb(RB_RELOAD_COUNT, 64'd5);
    for (int n = 0; n < 8; n++) begin
      send_sample(32'h7FFF_7FFF, 1'b0);
    end
    for (int n = 0; n < 8; n++) begin
      send_sample(32'h8000_8000, 1'b0);
    end
    for (int n = 0; n < 8; n++) begin
      send_sample(32'h7FFF_8000, n == 7);
    end
    finish_test("Test 5 saturation");

    $display("5 tests run, %0d failed, %0d outputs checked, %0d errors",
             tests_failed, out_count, tb_errors + chk_errors);
    if (tests_failed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_ce_clk);
    $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* fir_block.f */
source/fir_pkg.sv
source/fir_settings_regs.sv
source/fir_coeff_bank.sv
source/fir_core.sv
source/fir_round_clip.sv
source/fir_block_top.sv
testbench/fir_checker.sv
testbench/tb_fir_block.sv

/* Makefile */
SIM       = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_fir_block
FILELIST  = fir_block.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
